// File: verilog/rv32Pkg.sv
package rv32Pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regIdx_t;
	// extended immediate kept apart from word_t for readability
	typedef logic [31:0] imm_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_OR   = 4'd2,
		ALU_XOR  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRA  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SRL  = 4'd9
	} aluOp_e;

	// register and immediate ALU ops share CU_ALU
	typedef enum logic [5:0] {
		CU_LUI     = 6'd0,
		CU_AUIPC   = 6'd1,
		CU_JAL     = 6'd2,
		CU_JALR    = 6'd3,
		CU_BEQ     = 6'd4,
		CU_BNE     = 6'd5,
		CU_BLT     = 6'd6,
		CU_BGE     = 6'd7,
		CU_BLTU    = 6'd8,
		CU_BGEU    = 6'd9,
		CU_LB      = 6'd10,
		CU_LH      = 6'd11,
		CU_LW      = 6'd12,
		CU_LBU     = 6'd13,
		CU_LHU     = 6'd14,
		CU_SB      = 6'd15,
		CU_SH      = 6'd16,
		CU_SW      = 6'd17,
		CU_ALU     = 6'd18,
		CU_ILLEGAL = 6'd38
	} cuOp_e;

	typedef enum logic [2:0] {
		REQ_IDLE,
		REQ_FETCH_ISSUE,
		REQ_FETCH_WAIT,
		REQ_LOAD_ISSUE,
		REQ_LOAD_WAIT,
		REQ_STORE_ISSUE,
		REQ_STORE_WAIT
	} reqState_e;

	typedef enum logic [1:0] {
		WB_IDLE,
		WB_WRITE,
		WB_READ
	} wbState_e;

endpackage

// File: verilog/instrDecoder.sv
module instrDecoder import rv32Pkg::*; (
	input  word_t   instr_i,
	output regIdx_t rs1_o,
	output regIdx_t rs2_o,
	output regIdx_t rd_o,
	output aluOp_e  aluOp_o,
	output cuOp_e   cuOp_o,
	output logic    regWrite_o,
	output logic    aluSrc_o,
	output imm_t    imm_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	imm_t immI;
	imm_t immS;
	imm_t immB;
	imm_t immU;
	imm_t immJ;

	function automatic aluOp_e aluFn(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFn = alt ? ALU_SUB : ALU_ADD;
			3'b001: aluFn = ALU_SLL;
			3'b010: aluFn = ALU_SLT;
			3'b011: aluFn = ALU_SLTU;
			3'b100: aluFn = ALU_XOR;
			3'b101: aluFn = alt ? ALU_SRA : ALU_SRL;
			3'b110: aluFn = ALU_OR;
			default: aluFn = ALU_AND;
		endcase
	endfunction

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign rs1_o = instr_i[19:15];
	assign rs2_o = instr_i[24:20];
	assign rd_o = instr_i[11:7];

	assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
	assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign immU = {instr_i[31:12], 12'b0};
	assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		aluOp_o = ALU_ADD;
		cuOp_o = CU_ILLEGAL;
		aluSrc_o = 1'b0;
		imm_o = immI;
		// all-ones word stays illegal and runs as a no-op
		if (instr_i != '1) begin
			case (opcode)
				7'b0110111: begin
					cuOp_o = CU_LUI;
					imm_o = immU;
				end
				7'b0010111: begin
					cuOp_o = CU_AUIPC;
					imm_o = immU;
				end
				7'b1101111: begin
					cuOp_o = CU_JAL;
					imm_o = immJ;
				end
				7'b1100111: begin
					if (funct3 == 3'b000)
						cuOp_o = CU_JALR;
					aluSrc_o = 1'b1;
				end
				7'b1100011: begin
					imm_o = immB;
					aluOp_o = ALU_SUB;
					case (funct3)
						3'b000: cuOp_o = CU_BEQ;
						3'b001: cuOp_o = CU_BNE;
						3'b100: cuOp_o = CU_BLT;
						3'b101: cuOp_o = CU_BGE;
						3'b110: cuOp_o = CU_BLTU;
						3'b111: cuOp_o = CU_BGEU;
						default: cuOp_o = CU_ILLEGAL;
					endcase
				end
				7'b0000011: begin
					aluSrc_o = 1'b1;
					case (funct3)
						3'b000: cuOp_o = CU_LB;
						3'b001: cuOp_o = CU_LH;
						3'b010: cuOp_o = CU_LW;
						3'b100: cuOp_o = CU_LBU;
						3'b101: cuOp_o = CU_LHU;
						default: cuOp_o = CU_ILLEGAL;
					endcase
				end
				7'b0100011: begin
					imm_o = immS;
					aluSrc_o = 1'b1;
					case (funct3)
						3'b000: cuOp_o = CU_SB;
						3'b001: cuOp_o = CU_SH;
						3'b010: cuOp_o = CU_SW;
						default: cuOp_o = CU_ILLEGAL;
					endcase
				end
				7'b0010011: begin
					// bit 30 only selects SRAI, addi has no subtract form
					cuOp_o = CU_ALU;
					aluSrc_o = 1'b1;
					aluOp_o = aluFn(funct3, instr_i[30] && (funct3 == 3'b101));
				end
				7'b0110011: begin
					cuOp_o = CU_ALU;
					aluOp_o = aluFn(funct3, instr_i[30]);
				end
				default: cuOp_o = CU_ILLEGAL;
			endcase
		end
		regWrite_o = !(cuOp_o inside {CU_BEQ, CU_BNE, CU_BLT, CU_BGE, CU_BLTU, CU_BGEU,
			CU_SB, CU_SH, CU_SW, CU_ILLEGAL});
	end

endmodule

// File: verilog/aluUnit.sv
module aluUnit import rv32Pkg::*; (
	input  word_t  a_i,
	input  word_t  b_i,
	input  aluOp_e aluOp_i,
	output word_t  result_o,
	output logic   negative_o,
	output logic   zero_o
);

	always_comb begin
		case (aluOp_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_OR: result_o = a_i | b_i;
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_AND: result_o = a_i & b_i;
			ALU_SLL: result_o = a_i << b_i[4:0];
			ALU_SRA: result_o = word_t'($signed(a_i) >>> b_i[4:0]);
			ALU_SRL: result_o = a_i >> b_i[4:0];
			ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
			ALU_SLTU: result_o = {31'b0, a_i < b_i};
			default: result_o = '0;
		endcase
	end

	assign zero_o = (result_o == '0);

	// the flags only steer branches, so blt/bge get a true signed less-than
	// instead of the overflow-prone sign bit
	assign negative_o = (aluOp_i == ALU_SUB) ? ($signed(a_i) < $signed(b_i)) : result_o[31];

endmodule

// File: verilog/regFile.sv
module regFile import rv32Pkg::*; (
	input  logic    clk,
	input  logic    nRST,
	input  logic    we_i,
	input  regIdx_t wIdx_i,
	input  word_t   wData_i,
	input  regIdx_t rIdx1_i,
	input  regIdx_t rIdx2_i,
	output word_t   rData1_o,
	output word_t   rData2_o
);

	word_t regs [32];

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we_i && (wIdx_i != '0)) begin
			regs[wIdx_i] <= wData_i;
		end
	end

	// x0 stays zero since it is never written
	assign rData1_o = regs[rIdx1_i];
	assign rData2_o = regs[rIdx2_i];

endmodule

// File: verilog/pcUnit.sv
module pcUnit import rv32Pkg::*; #(
	parameter word_t RESET_VECTOR = 32'h3300_0000
) (
	input  logic  clk,
	input  logic  nRST,
	input  logic  instrValid_i,
	input  cuOp_e cuOp_i,
	input  word_t rs1_i,
	input  imm_t  imm_i,
	input  logic  negative_i,
	input  logic  zero_i,
	input  logic  ltu_i,
	output word_t pc_o
);

	logic taken;
	word_t nextPc;

	always_comb begin
		case (cuOp_i)
			CU_JAL: taken = 1'b1;
			CU_BEQ: taken = zero_i;
			CU_BNE: taken = !zero_i;
			CU_BLT: taken = negative_i;
			CU_BGE: taken = !negative_i;
			// unsigned branches use the compare from the top level
			CU_BLTU: taken = ltu_i;
			CU_BGEU: taken = !ltu_i;
			default: taken = 1'b0;
		endcase
		if (cuOp_i == CU_JALR)
			nextPc = (rs1_i + imm_i) & ~32'd1;
		else if (taken)
			nextPc = pc_o + imm_i;
		else
			nextPc = pc_o + 32'd4;
	end

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST)
			pc_o <= RESET_VECTOR;
		else if (instrValid_i)
			pc_o <= nextPc;
	end

endmodule

// File: verilog/writeBack.sv
module writeBack import rv32Pkg::*; (
	input  cuOp_e cuOp_i,
	input  word_t loadData_i,
	input  word_t pc_i,
	input  word_t aluResult_i,
	input  imm_t  imm_i,
	output word_t wData_o
);

	always_comb begin
		case (cuOp_i)
			// sub-word loads take the low lanes of the bus word
			CU_LB: wData_o = {{24{loadData_i[7]}}, loadData_i[7:0]};
			CU_LH: wData_o = {{16{loadData_i[15]}}, loadData_i[15:0]};
			CU_LW: wData_o = loadData_i;
			CU_LBU: wData_o = {24'b0, loadData_i[7:0]};
			CU_LHU: wData_o = {16'b0, loadData_i[15:0]};
			CU_LUI: wData_o = imm_i;
			CU_AUIPC: wData_o = pc_i + imm_i;
			CU_JAL,
			CU_JALR: wData_o = pc_i + 32'd4;
			default: wData_o = aluResult_i;
		endcase
	end

endmodule

// File: verilog/memRequest.sv
module memRequest import rv32Pkg::*; #(
	parameter word_t DATA_BASE = 32'h3300_0000
) (
	input  logic  clk,
	input  logic  nRST,
	input  word_t pc_i,
	input  word_t dataAddr_i,
	input  word_t storeData_i,
	input  cuOp_e cuOp_i,
	input  logic  busy_i,
	input  word_t busData_i,
	output logic  rdReq_o,
	output logic  wrReq_o,
	output word_t busAddr_o,
	output word_t busStore_o,
	output word_t instr_o,
	output word_t loadData_o,
	output logic  instrValid_o,
	output logic  dataValid_o
);

	reqState_e state;
	logic dataDone;
	logic isLoad;
	logic isStore;

	assign isLoad = cuOp_i inside {CU_LB, CU_LH, CU_LW, CU_LBU, CU_LHU};
	assign isStore = cuOp_i inside {CU_SB, CU_SH, CU_SW};

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST) begin
			state <= REQ_IDLE;
			rdReq_o <= 1'b0;
			wrReq_o <= 1'b0;
			instrValid_o <= 1'b0;
			dataValid_o <= 1'b0;
			dataDone <= 1'b0;
			instr_o <= '0;
		end else begin
			rdReq_o <= 1'b0;
			wrReq_o <= 1'b0;
			instrValid_o <= 1'b0;
			dataValid_o <= 1'b0;
			case (state)
				REQ_IDLE: begin
					// held instruction gets its data access before the next fetch
					if (isLoad && !dataDone) begin
						rdReq_o <= 1'b1;
						state <= REQ_LOAD_ISSUE;
					end else if (isStore && !dataDone) begin
						wrReq_o <= 1'b1;
						state <= REQ_STORE_ISSUE;
					end else begin
						rdReq_o <= 1'b1;
						state <= REQ_FETCH_ISSUE;
					end
				end
				REQ_FETCH_ISSUE: state <= REQ_FETCH_WAIT;
				REQ_LOAD_ISSUE: state <= REQ_LOAD_WAIT;
				REQ_STORE_ISSUE: state <= REQ_STORE_WAIT;
				REQ_FETCH_WAIT: begin
					if (!busy_i) begin
						instr_o <= busData_i;
						instrValid_o <= 1'b1;
						dataDone <= 1'b0;
						state <= REQ_IDLE;
					end
				end
				REQ_LOAD_WAIT,
				REQ_STORE_WAIT: begin
					if (!busy_i) begin
						dataValid_o <= 1'b1;
						dataDone <= 1'b1;
						state <= REQ_IDLE;
					end
				end
				default: state <= REQ_IDLE;
			endcase
		end
	end

	// pc has already advanced by the time the fetch issue state runs
	always_ff @(posedge clk) begin
		case (state)
			REQ_FETCH_ISSUE: busAddr_o <= pc_i;
			REQ_LOAD_ISSUE: busAddr_o <= dataAddr_i + DATA_BASE;
			REQ_STORE_ISSUE: begin
				busAddr_o <= dataAddr_i + DATA_BASE;
				busStore_o <= storeData_i;
			end
			REQ_LOAD_WAIT: begin
				if (!busy_i)
					loadData_o <= busData_i;
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/wishboneManager.sv
module wishboneManager import rv32Pkg::*; (
	input  logic  clk,
	input  logic  nRST,
	input  logic  rdReq_i,
	input  logic  wrReq_i,
	input  word_t addr_i,
	input  word_t store_i,
	input  word_t wbDat_i,
	input  logic  wbAck_i,
	output logic  busy_o,
	output word_t rdData_o,
	output word_t wbAdr_o,
	output word_t wbDat_o,
	output logic  wbWe_o,
	output logic  wbStb_o,
	output logic  wbCyc_o
);

	wbState_e state;
	logic ackSeen;

	// ack only counts while the strobe is out
	assign ackSeen = wbStb_o && wbAck_i;

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST) begin
			state <= WB_IDLE;
			busy_o <= 1'b0;
			wbWe_o <= 1'b0;
			wbStb_o <= 1'b0;
			wbCyc_o <= 1'b0;
		end else begin
			case (state)
				WB_IDLE: begin
					if (wrReq_i && !rdReq_i) begin
						busy_o <= 1'b1;
						state <= WB_WRITE;
					end else if (rdReq_i && !wrReq_i) begin
						busy_o <= 1'b1;
						state <= WB_READ;
					end
				end
				WB_WRITE,
				WB_READ: begin
					if (ackSeen) begin
						busy_o <= 1'b0;
						wbWe_o <= 1'b0;
						wbStb_o <= 1'b0;
						wbCyc_o <= 1'b0;
						state <= WB_IDLE;
					end else begin
						wbWe_o <= (state == WB_WRITE);
						wbStb_o <= 1'b1;
						wbCyc_o <= 1'b1;
					end
				end
				default: state <= WB_IDLE;
			endcase
		end
	end

	// request side holds address and data for the whole access
	always_ff @(posedge clk) begin
		if ((state != WB_IDLE) && !ackSeen) begin
			wbAdr_o <= addr_i;
			wbDat_o <= store_i;
		end
		if ((state == WB_READ) && ackSeen)
			rdData_o <= wbDat_i;
	end

endmodule

// File: verilog/rv32Top.sv
module rv32Top import rv32Pkg::*; #(
	parameter word_t RESET_VECTOR = 32'h3300_0000,
	parameter word_t DATA_BASE = 32'h3300_0000
) (
	input  logic  clk,
	input  logic  nRST,
	input  word_t wbDat_i,
	input  logic  wbAck_i,
	output word_t wbAdr_o,
	output word_t wbDat_o,
	output logic  wbWe_o,
	output logic  wbStb_o,
	output logic  wbCyc_o
);

	word_t instr;
	regIdx_t rs1;
	regIdx_t rs2;
	regIdx_t rd;
	aluOp_e aluOp;
	cuOp_e cuOp;
	logic regWrite;
	logic aluSrc;
	imm_t imm;
	word_t rData1;
	word_t rData2;
	word_t aluB;
	word_t aluResult;
	logic negative;
	logic zero;
	logic ltu;
	word_t pc;
	word_t loadData;
	word_t wData;
	logic rfWe;
	logic instrValid;
	logic dataValid;
	logic rdReq;
	logic wrReq;
	word_t busAddr;
	word_t busStore;
	logic busy;
	word_t rdData;

	assign aluB = aluSrc ? imm : rData2;
	assign ltu = rData1 < rData2;

	// loads commit when their data returns, everything else on fetch
	assign rfWe = regWrite && ((cuOp inside {CU_LB, CU_LH, CU_LW, CU_LBU, CU_LHU}) ?
		dataValid : instrValid);

	instrDecoder u_instrDecoder (
		.instr_i(instr),
		.rs1_o(rs1),
		.rs2_o(rs2),
		.rd_o(rd),
		.aluOp_o(aluOp),
		.cuOp_o(cuOp),
		.regWrite_o(regWrite),
		.aluSrc_o(aluSrc),
		.imm_o(imm)
	);

	aluUnit u_aluUnit (
		.a_i(rData1),
		.b_i(aluB),
		.aluOp_i(aluOp),
		.result_o(aluResult),
		.negative_o(negative),
		.zero_o(zero)
	);

	regFile u_regFile (
		.clk(clk),
		.nRST(nRST),
		.we_i(rfWe),
		.wIdx_i(rd),
		.wData_i(wData),
		.rIdx1_i(rs1),
		.rIdx2_i(rs2),
		.rData1_o(rData1),
		.rData2_o(rData2)
	);

	pcUnit #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_pcUnit (
		.clk(clk),
		.nRST(nRST),
		.instrValid_i(instrValid),
		.cuOp_i(cuOp),
		.rs1_i(rData1),
		.imm_i(imm),
		.negative_i(negative),
		.zero_i(zero),
		.ltu_i(ltu),
		.pc_o(pc)
	);

	writeBack u_writeBack (
		.cuOp_i(cuOp),
		.loadData_i(loadData),
		.pc_i(pc),
		.aluResult_i(aluResult),
		.imm_i(imm),
		.wData_o(wData)
	);

	memRequest #(
		.DATA_BASE(DATA_BASE)
	) u_memRequest (
		.clk(clk),
		.nRST(nRST),
		.pc_i(pc),
		.dataAddr_i(aluResult),
		.storeData_i(rData2),
		.cuOp_i(cuOp),
		.busy_i(busy),
		.busData_i(rdData),
		.rdReq_o(rdReq),
		.wrReq_o(wrReq),
		.busAddr_o(busAddr),
		.busStore_o(busStore),
		.instr_o(instr),
		.loadData_o(loadData),
		.instrValid_o(instrValid),
		.dataValid_o(dataValid)
	);

	wishboneManager u_wishboneManager (
		.clk(clk),
		.nRST(nRST),
		.rdReq_i(rdReq),
		.wrReq_i(wrReq),
		.addr_i(busAddr),
		.store_i(busStore),
		.wbDat_i(wbDat_i),
		.wbAck_i(wbAck_i),
		.busy_o(busy),
		.rdData_o(rdData),
		.wbAdr_o(wbAdr_o),
		.wbDat_o(wbDat_o),
		.wbWe_o(wbWe_o),
		.wbStb_o(wbStb_o),
		.wbCyc_o(wbCyc_o)
	);

endmodule

// File: tb/rv32Top_assertions.sv
module rv32Top_assertions (
	input logic        clk,
	input logic        nRST,
	input logic        wbAck_i,
	input logic [31:0] wbAdr_o,
	input logic        wbWe_o,
	input logic        wbStb_o,
	input logic        wbCyc_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// a strobe is only legal inside a cycle
	stbInCyc: assert property (@(posedge clk) disable iff (!nRST)
		wbStb_o |-> wbCyc_o)
		else $error("STB high while CYC is low");

	// request must not move while the slave stalls
	holdRequest: assert property (@(posedge clk) disable iff (!nRST)
		(wbStb_o && !wbAck_i) |=> ($stable(wbAdr_o) && $stable(wbWe_o)))
		else $error("address or WE changed before ACK");

	cycEnds: assert property (@(posedge clk) disable iff (!nRST)
		(wbStb_o && wbAck_i) |=> !wbCyc_o)
		else $error("CYC still high in the cycle after ACK");

endmodule

bind wishboneManager rv32Top_assertions u_rv32Top_assertions (
	.clk(clk),
	.nRST(nRST),
	.wbAck_i(wbAck_i),
	.wbAdr_o(wbAdr_o),
	.wbWe_o(wbWe_o),
	.wbStb_o(wbStb_o),
	.wbCyc_o(wbCyc_o)
);

// File: tb/rv32Top_tb.sv
module rv32Top_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RESET_VECTOR = 32'h3300_0000;
	localparam logic [31:0] DATA_BASE = 32'h3300_0000;
	localparam int MEM_WORDS = 256;
	// word index where the expected store list starts in the image
	localparam int EXP_BASE = 192;
	localparam int MAX_STORES = 31;

	logic clk;
	logic nRST;
	logic [31:0] wbDatIn;
	logic wbAck;
	logic [31:0] wbAdr;
	logic [31:0] wbDatOut;
	logic wbWe;
	logic wbStb;
	logic wbCyc;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] expAdr [MAX_STORES];
	logic [31:0] expDat [MAX_STORES];
	integer expCount;
	integer storeIdx;
	integer readCount;
	integer errors;
	integer timeouts;
	integer seed;
	integer waitLeft;
	logic inCycle;
	logic sawFirst;
	logic [31:0] firstAdr;
	logic firstWe;

	rv32Top #(
		.RESET_VECTOR(RESET_VECTOR),
		.DATA_BASE(DATA_BASE)
	) u_rv32Top (
		.clk(clk),
		.nRST(nRST),
		.wbDat_i(wbDatIn),
		.wbAck_i(wbAck),
		.wbAdr_o(wbAdr),
		.wbDat_o(wbDatOut),
		.wbWe_o(wbWe),
		.wbStb_o(wbStb),
		.wbCyc_o(wbCyc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic inMemory(input logic [31:0] adr);
		return adr[31:10] == RESET_VECTOR[31:10];
	endfunction

	task automatic compareStore(input logic [31:0] adr, input logic [31:0] dat);
		if (storeIdx >= expCount) begin
			$display("CHECK FAILED at %0t: extra store of %h to %h", $time, dat, adr);
			errors = errors + 1;
		end else begin
			if (adr !== expAdr[storeIdx]) begin
				$display("CHECK FAILED at %0t: store %0d address %h, expected %h",
					$time, storeIdx, adr, expAdr[storeIdx]);
				errors = errors + 1;
			end
			if (dat !== expDat[storeIdx]) begin
				$display("CHECK FAILED at %0t: store %0d data %h, expected %h",
					$time, storeIdx, dat, expDat[storeIdx]);
				errors = errors + 1;
			end
		end
		storeIdx = storeIdx + 1;
	endtask

	// slave model samples the bus before the edge updates it
	always @(posedge clk) begin : memModel
		integer left;
		if (!nRST) begin
			wbAck <= 1'b0;
			inCycle <= 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0;
			inCycle <= 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!sawFirst) begin
				sawFirst <= 1'b1;
				firstAdr <= wbAdr;
				firstWe <= wbWe;
			end
			if (!inCycle) begin
				inCycle <= 1'b1;
				left = {$random(seed)} % 4;
			end else begin
				left = waitLeft;
			end
			if (left == 0) begin
				wbAck <= 1'b1;
				if (!inMemory(wbAdr)) begin
					$display("bus access at %h lies outside the memory model", wbAdr);
					errors = errors + 1;
				end else if (wbWe) begin
					mem[wbAdr[9:2]] <= wbDatOut;
					compareStore(wbAdr, wbDatOut);
				end else begin
					wbDatIn <= mem[wbAdr[9:2]];
					readCount = readCount + 1;
				end
			end else begin
				waitLeft <= left - 1;
			end
		end
	end

	initial begin : mainFlow
		integer cycles;
		integer readsAt;
		logic timedOut;
		seed = 32'h0a0e_dd50;
		errors = 0;
		timeouts = 0;
		storeIdx = 0;
		readCount = 0;
		waitLeft = 0;
		inCycle = 1'b0;
		sawFirst = 1'b0;
		firstAdr = '0;
		firstWe = 1'b0;
		timedOut = 1'b0;
		nRST = 1'b0;
		wbAck = 1'b0;
		wbDatIn = '0;
		$readmemh("tb/rv32Top_stimulus.hex", mem);
		expCount = mem[EXP_BASE];
		if (expCount > MAX_STORES) begin
			$display("stimulus lists %0d stores, more than the testbench holds", expCount);
			errors = errors + 1;
			expCount = MAX_STORES;
		end
		for (int i = 0; i < expCount; i++) begin
			expAdr[i] = mem[EXP_BASE + 1 + 2 * i];
			expDat[i] = mem[EXP_BASE + 2 + 2 * i];
		end

		repeat (3) @(posedge clk);
		nRST <= 1'b1;
		@(negedge clk);
		if (wbCyc !== 1'b0 || wbStb !== 1'b0) begin
			$display("CHECK FAILED at %0t: CYC or STB active after reset", $time);
			errors = errors + 1;
		end

		// first access has to be an instruction read at the reset vector
		cycles = 0;
		while (!sawFirst && cycles < 50) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!sawFirst) begin
			$display("timeout: no bus cycle started after reset");
			timeouts = timeouts + 1;
			timedOut = 1'b1;
		end else if (firstAdr !== RESET_VECTOR || firstWe !== 1'b0) begin
			$display("CHECK FAILED at %0t: first access %h we %b, expected read at %h",
				$time, firstAdr, firstWe, RESET_VECTOR);
			errors = errors + 1;
		end

		if (!timedOut) begin
			cycles = 0;
			while (storeIdx < expCount && cycles < 5000) begin
				@(negedge clk);
				cycles = cycles + 1;
			end
			if (storeIdx < expCount) begin
				$display("timeout: only %0d of %0d stores seen", storeIdx, expCount);
				timeouts = timeouts + 1;
				timedOut = 1'b1;
			end
		end

		// let the final loop spin a while to catch stray stores
		if (!timedOut) begin
			readsAt = readCount;
			cycles = 0;
			while (readCount < readsAt + 10 && cycles < 2000) begin
				@(negedge clk);
				cycles = cycles + 1;
			end
			if (readCount < readsAt + 10) begin
				$display("timeout: core stopped fetching after the last store");
				timeouts = timeouts + 1;
			end
		end

		$display("errors: %0d, timeouts: %0d, stores: %0d of %0d",
			errors, timeouts, storeIdx, expCount);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: tb/rv32Top_stimulus.hex
// program words from the reset vector, one instruction per line
// at word c0 the store count, then expected store address and data per line
@00
00500093
FFD00113
002081B3
20302023
40110233
20402223
00409293
40125313
01C25393
0072E433
00644433
20802423
001124B3
00113533
0F027593
00B484B3
00A4E4B3
0060B513
00851513
00A484B3
20902623
00708013
20002823
FFFF8837
0F080813
21002A23
21400603
21404683
21401703
21405783
20C02C23
20D02E23
22E02023
22F02223
00001997
23302423
00108463
2E002823
00109463
00114463
2E002823
0020F463
00117463
2E002823
05500A13
23402623
00C008EF
2E002823
2E002823
23102823
01888967
2E002823
2E002823
23202A23
0000006F
@c0
0000000E
33000200 00000002
33000204 FFFFFFF8
33000208 FFFFFFA3
3300020C 000001F1
33000210 00000000
33000214 FFFF80F0
33000218 FFFFFFF0
3300021C 000000F0
33000220 FFFF80F0
33000224 000080F0
33000228 33001088
3300022C 00000055
33000230 330000BC
33000234 330000CC

// File: rv32Core.f
verilog/rv32Pkg.sv
verilog/instrDecoder.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/pcUnit.sv
verilog/writeBack.sv
verilog/memRequest.sv
verilog/wishboneManager.sv
verilog/rv32Top.sv
tb/rv32Top_assertions.sv
tb/rv32Top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= rv32Top_tb
FILELIST ?= rv32Core.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

BIN = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
